// ==== bench/spidergon_node_cases.txt ====
// port vc kind dest src payload adj_vc_full adj_vc_free hold, all hex, one flit per line
// port 0 anticlockwise 1 clockwise 2 across 3 flags only; kind 0 tail 1 head 2 body 3 header
// routing, a header to every destination from node 2
2 0 3 0 5 011 00 3f 0
1 1 3 1 1 022 00 3f 0
0 0 3 2 3 033 00 3f 0
2 1 3 3 6 044 00 3f 0
1 0 3 4 1 055 00 3f 0
0 1 3 5 3 066 00 3f 0
2 0 3 6 5 077 00 3f 0
1 1 3 7 1 088 00 3f 4
// reservation, a four-flit packet on clockwise vc 1 going across
1 1 1 6 1 101 00 3f 0
1 1 2 0 1 102 00 3f 0
1 1 2 0 1 103 00 3f 0
1 1 0 0 1 104 00 3f 4
// wormhole lock, two packets from different ports and vcs, both to the clockwise output
2 0 1 3 6 201 00 3f 0
0 1 1 4 1 301 00 3f 0
2 0 2 0 6 202 00 3f 0
0 1 2 0 1 302 00 3f 0
2 0 2 0 6 203 00 3f 0
2 0 0 0 6 204 00 3f 0
0 1 2 0 1 303 00 3f 0
0 1 0 0 1 304 00 3f 4
// back-pressure, clockwise vc 0 full at the neighbour until the flags-only line
2 0 1 3 6 401 04 3f 0
2 0 2 0 6 402 04 3f 6
3 0 0 0 0 000 00 3f 0
2 0 2 0 6 403 00 3f 0
2 0 0 0 6 404 00 3f 4
// a header held back while the neighbour's across vc 1 is taken
0 1 3 7 1 501 00 1f 5
3 0 0 0 0 000 00 3f 0
ff 0 0 0 0 000 00 00 0

// ==== spidergon_node.f ====
logic/noc_pkg.sv
logic/vc_port_if.sv
logic/vc_fifo.sv
logic/input_port.sv
logic/rr_arbiter.sv
logic/output_switch.sv
logic/spidergon_node.sv
bench/spidergon_node_tb.sv

// ==== Bender.yml ====
package:
  name: spidergon_node

sources:
  - logic/noc_pkg.sv
  - logic/vc_port_if.sv
  - logic/vc_fifo.sv
  - logic/input_port.sv
  - logic/rr_arbiter.sv
  - logic/output_switch.sv
  - logic/spidergon_node.sv
  - target: simulation
    files:
      - bench/spidergon_node_tb.sv

// ==== bench/spidergon_node_tb.sv ====
// testbench for one spidergon node at position 2 that replays the cases file and checks every cycle
`timescale 1ns/100ps

module spidergon_node_tb;
	import noc_pkg::*;

	localparam int this_node = 2;
	localparam int max_words = 512;
	localparam int rec_words = 9;
	localparam int wait_limit = 200;

	logic clk;
	logic reset;
	flit_t in_flit_across;
	flit_t in_flit_clockwise;
	flit_t in_flit_anticlockwise;
	logic [2:0] in_valid;
	logic [5:0] vc_free;
	logic [5:0] vc_full;
	flit_t out_flit_across;
	flit_t out_flit_clockwise;
	flit_t out_flit_anticlockwise;
	logic [2:0] out_valid;
	logic [5:0] adj_vc_free;
	logic [5:0] adj_vc_full;
	flit_t eject_flit;
	logic eject_valid;

	// nine hex words per case line as listed at the top of the cases file
	logic [15:0] case_words [max_words];

	// expected flits per output with their source buffer tagged in the top three bits
	logic [20:0] exp_q [4][$];
	int exp_count [6];
	logic [5:0] exp_reserved;
	logic [1:0] pkt_port [6];
	logic [3:0] run_active;
	logic [2:0] run_src [4];
	int flit_errors;
	int flag_errors;
	int other_errors;
	logic timed_out;

	spidergon_node #(
		.node_id(3'(this_node))
	) i_spidergon_node (
		.clk(clk),
		.reset(reset),
		.in_flit_across(in_flit_across),
		.in_flit_clockwise(in_flit_clockwise),
		.in_flit_anticlockwise(in_flit_anticlockwise),
		.in_valid(in_valid),
		.vc_free(vc_free),
		.vc_full(vc_full),
		.out_flit_across(out_flit_across),
		.out_flit_clockwise(out_flit_clockwise),
		.out_flit_anticlockwise(out_flit_anticlockwise),
		.out_valid(out_valid),
		.adj_vc_free(adj_vc_free),
		.adj_vc_full(adj_vc_full),
		.eject_flit(eject_flit),
		.eject_valid(eject_valid)
	);

	initial
		clk = 1'b0;

	always #50 clk = ~clk;

	// shortest path on the ring, worked out from the clockwise distance
	function automatic logic [1:0] expected_port(input logic [2:0] dest);
		logic [2:0] d;
		d = dest - 3'(this_node);
		if (d == 3'd0)
			return 2'd3;
		else if (d <= 3'd2)
			return 2'd1;
		else if (d >= 3'd6)
			return 2'd0;
		else
			return 2'd2;
	endfunction

	function automatic logic is_opening(input flit_t f);
		return (f.kind == kind_head) || (f.kind == kind_header);
	endfunction

	function automatic string output_name(input int o);
		case (o)
			0: return "out_flit_anticlockwise";
			1: return "out_flit_clockwise";
			2: return "out_flit_across";
			default: return "eject_flit";
		endcase
	endfunction

	function automatic logic observed_valid(input int o);
		return (o < 3) ? out_valid[o] : eject_valid;
	endfunction

	function automatic flit_t observed_flit(input int o);
		case (o)
			0: return out_flit_anticlockwise;
			1: return out_flit_clockwise;
			2: return out_flit_across;
			default: return eject_flit;
		endcase
	endfunction

	function automatic flit_t driven_flit(input int p);
		case (p)
			0: return in_flit_anticlockwise;
			1: return in_flit_clockwise;
			default: return in_flit_across;
		endcase
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		for (int o = 0; o < 4; o++)
			n += exp_q[o].size();
		return n;
	endfunction

	// match each valid output against the packets waiting for it
	task automatic check_outputs();
		flit_t obs;
		flit_t want;
		logic [5:0] seen;
		logic ok;
		int idx;
		int b;
		int fb;
		for (int o = 0; o < 4; o++)
		begin
			if (observed_valid(o))
			begin
				obs = observed_flit(o);
				idx = -1;
				seen = '0;
				// inside a run only the locked buffer may continue
				for (int i = 0; i < exp_q[o].size(); i++)
				begin
					b = exp_q[o][i][20:18];
					if (run_active[o] && idx < 0 && b == run_src[o])
						idx = i;
					else if (!run_active[o] && idx < 0 && !seen[b] && exp_q[o][i][17:0] === obs)
						idx = i;
					seen[b] = 1'b1;
				end
				// outside a run a flit that fits no packet is held against the oldest one waiting
				if (idx < 0 && !run_active[o] && exp_q[o].size() > 0)
					idx = 0;
				assert (idx >= 0) else
				begin
					$display("unexpected flit %h on %s, no packet waiting there could send it",
						obs, output_name(o));
					other_errors++;
				end
				if (idx >= 0)
				begin
					want = exp_q[o][idx][17:0];
					b = exp_q[o][idx][20:18];
					assert (obs === want) else
					begin
						$display("ERR %s got %h expected %h", output_name(o), obs, want);
						flit_errors++;
					end
					exp_q[o].delete(idx);
					exp_count[b]--;
					// the reservation ends with the last flit of the packet
					if (want.kind == kind_tail || want.kind == kind_header)
						exp_reserved[b] = 1'b0;
					if (want.kind == kind_head)
					begin
						run_active[o] = 1'b1;
						run_src[o] = 3'(b);
					end
					else if (want.kind == kind_tail)
						run_active[o] = 1'b0;
				end
				// the neighbour flags seen at the grant edge are still on the inputs
				if (o < 3)
				begin
					fb = o * 2 + obs.vc;
					if (is_opening(obs))
						ok = adj_vc_free[fb] && !adj_vc_full[fb];
					else
						ok = !adj_vc_full[fb];
					assert (ok) else
					begin
						$display("flit %h left on %s although the neighbour could not take it",
							obs, output_name(o));
						other_errors++;
					end
				end
			end
		end
	endtask

	// a flit driven before the last edge went into its buffer, as the buffer had room
	task automatic account_accepted();
		flit_t f;
		int b;
		for (int p = 0; p < 3; p++)
		begin
			if (in_valid[p])
			begin
				f = driven_flit(p);
				b = p * 2 + f.vc;
				exp_count[b]++;
				if (is_opening(f))
				begin
					exp_reserved[b] = 1'b1;
					pkt_port[b] = expected_port(f.data[14:12]);
				end
				exp_q[pkt_port[b]].push_back({3'(b), f});
			end
		end
	endtask

	task automatic check_flags();
		logic [5:0] want_full;
		for (int b = 0; b < 6; b++)
			want_full[b] = (exp_count[b] >= vc_depth);
		assert (vc_free === ~exp_reserved) else
		begin
			$display("ERR vc_free got %h expected %h", vc_free, ~exp_reserved);
			flag_errors++;
		end
		assert (vc_full === want_full) else
		begin
			$display("ERR vc_full got %h expected %h", vc_full, want_full);
			flag_errors++;
		end
	endtask

	// one clock cycle with outputs and flags checked at the falling edge where they are stable
	task automatic step();
		@(negedge clk);
		check_outputs();
		account_accepted();
		check_flags();
		in_valid = '0;
	endtask

	task automatic drive_flit(input int p, input flit_t f);
		case (p)
			0: in_flit_anticlockwise = f;
			1: in_flit_clockwise = f;
			default: in_flit_across = f;
		endcase
		in_valid[p] = 1'b1;
	endtask

	task automatic wait_for_space(input int b);
		int n;
		n = 0;
		while (vc_full[b] && n < wait_limit)
		begin
			step();
			n++;
		end
		if (vc_full[b])
		begin
			$display("timeout while waiting for room in buffer %0d", b);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_drain();
		int n;
		n = 0;
		while (pending() > 0 && n < wait_limit)
		begin
			step();
			n++;
		end
		if (pending() > 0)
		begin
			$display("timeout, %0d expected flits never left the node", pending());
			timed_out = 1'b1;
		end
	endtask

	// port 3 in a case line only changes the neighbour flags and holds them
	task automatic run_case(input int r);
		logic [15:0] w [rec_words];
		flit_t f;
		for (int i = 0; i < rec_words; i++)
			w[i] = case_words[r * rec_words + i];
		adj_vc_full = w[6][5:0];
		adj_vc_free = w[7][5:0];
		if (w[0] < 16'd3)
		begin
			f.kind = flit_kind_t'(w[2][1:0]);
			f.vc = w[1][0];
			f.data = {w[3][2:0], w[4][2:0], w[5][8:0]};
			wait_for_space(int'(w[0]) * 2 + w[1][0]);
			if (!timed_out)
			begin
				drive_flit(int'(w[0]), f);
				step();
			end
		end
		if (!timed_out)
			repeat (w[8]) step();
	endtask

	initial
	begin
		int r;
		reset = 1'b1;
		in_flit_across = '0;
		in_flit_clockwise = '0;
		in_flit_anticlockwise = '0;
		in_valid = '0;
		adj_vc_free = '1;
		adj_vc_full = '0;
		exp_reserved = '0;
		run_active = '0;
		for (int b = 0; b < 6; b++)
		begin
			exp_count[b] = 0;
			pkt_port[b] = 2'd3;
		end
		flit_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		timed_out = 1'b0;
		$readmemh("bench/spidergon_node_cases.txt", case_words);
		if ($isunknown(case_words[0]))
		begin
			$display("the cases file could not be read");
			other_errors++;
		end
		repeat (8) @(negedge clk);
		// still in reset here, so no valid may be up and all channels must be free
		assert (out_valid === 3'b000) else
		begin
			$display("ERR out_valid got %h expected %h", out_valid, 3'b000);
			other_errors++;
		end
		assert (eject_valid === 1'b0) else
		begin
			$display("ERR eject_valid got %h expected %h", eject_valid, 1'b0);
			other_errors++;
		end
		check_outputs();
		check_flags();
		reset = 1'b0;
		r = 0;
		while (!timed_out && (r + 1) * rec_words <= max_words &&
			!$isunknown(case_words[r * rec_words]) && case_words[r * rec_words] != 16'h00ff)
		begin
			run_case(r);
			r++;
		end
		if (!timed_out)
			wait_for_drain();
		// a few quiet cycles catch stray flits and late flag changes
		if (!timed_out)
			repeat (4) step();
		$display("%0d case lines, errors: flit %0d, flag %0d, other %0d",
			r, flit_errors, flag_errors, other_errors);
		if (flit_errors == 0 && flag_errors == 0 && other_errors == 0 && !timed_out)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== logic/spidergon_node.sv ====
// top level of one spidergon router node, connecting three input ports to the output switch
`timescale 1ns/100ps

module spidergon_node #(
	parameter logic [noc_pkg::node_w-1:0] node_id = 0
) (
	input logic clk,
	input logic reset,
	input noc_pkg::flit_t in_flit_across,
	input noc_pkg::flit_t in_flit_clockwise,
	input noc_pkg::flit_t in_flit_anticlockwise,
	input logic [noc_pkg::num_ports-1:0] in_valid,
	output logic [noc_pkg::num_ports*noc_pkg::num_vcs-1:0] vc_free,
	output logic [noc_pkg::num_ports*noc_pkg::num_vcs-1:0] vc_full,
	output noc_pkg::flit_t out_flit_across,
	output noc_pkg::flit_t out_flit_clockwise,
	output noc_pkg::flit_t out_flit_anticlockwise,
	output logic [noc_pkg::num_ports-1:0] out_valid,
	input logic [noc_pkg::num_ports*noc_pkg::num_vcs-1:0] adj_vc_free,
	input logic [noc_pkg::num_ports*noc_pkg::num_vcs-1:0] adj_vc_full,
	output noc_pkg::flit_t eject_flit,
	output logic eject_valid
);
	import noc_pkg::*;

	flit_t out_flit [num_ports];

	vc_port_if across_bufs ();
	vc_port_if clockwise_bufs ();
	vc_port_if anticlockwise_bufs ();

	// flag bits for each input port sit at port*num_vcs
	input_port i_input_port_across (
		.clk(clk),
		.reset(reset),
		.flit(in_flit_across),
		.valid(in_valid[port_across]),
		.vc_free(vc_free[port_across*num_vcs +: num_vcs]),
		.vc_full(vc_full[port_across*num_vcs +: num_vcs]),
		.bufs(across_bufs.buffer)
	);

	input_port i_input_port_clockwise (
		.clk(clk),
		.reset(reset),
		.flit(in_flit_clockwise),
		.valid(in_valid[port_clockwise]),
		.vc_free(vc_free[port_clockwise*num_vcs +: num_vcs]),
		.vc_full(vc_full[port_clockwise*num_vcs +: num_vcs]),
		.bufs(clockwise_bufs.buffer)
	);

	input_port i_input_port_anticlockwise (
		.clk(clk),
		.reset(reset),
		.flit(in_flit_anticlockwise),
		.valid(in_valid[port_anticlockwise]),
		.vc_free(vc_free[port_anticlockwise*num_vcs +: num_vcs]),
		.vc_full(vc_full[port_anticlockwise*num_vcs +: num_vcs]),
		.bufs(anticlockwise_bufs.buffer)
	);

	output_switch #(
		.node_id(node_id)
	) i_output_switch (
		.clk(clk),
		.reset(reset),
		.across_bufs(across_bufs.switch),
		.clockwise_bufs(clockwise_bufs.switch),
		.anticlockwise_bufs(anticlockwise_bufs.switch),
		.adj_vc_free(adj_vc_free),
		.adj_vc_full(adj_vc_full),
		.out_flit(out_flit),
		.out_valid(out_valid),
		.eject_flit(eject_flit),
		.eject_valid(eject_valid)
	);

	// switch outputs are indexed by direction code
	assign out_flit_across = out_flit[port_across];
	assign out_flit_clockwise = out_flit[port_clockwise];
	assign out_flit_anticlockwise = out_flit[port_anticlockwise];

endmodule

// ==== logic/output_switch.sv ====
// switch allocation that routes buffer fronts to the three links and the ejection port
`timescale 1ns/100ps

module output_switch #(
	parameter logic [noc_pkg::node_w-1:0] node_id = '0
) (
	input logic clk,
	input logic reset,
	vc_port_if.switch across_bufs,
	vc_port_if.switch clockwise_bufs,
	vc_port_if.switch anticlockwise_bufs,
	input logic [noc_pkg::num_ports*noc_pkg::num_vcs-1:0] adj_vc_free,
	input logic [noc_pkg::num_ports*noc_pkg::num_vcs-1:0] adj_vc_full,
	output noc_pkg::flit_t out_flit [noc_pkg::num_ports],
	output logic [noc_pkg::num_ports-1:0] out_valid,
	output noc_pkg::flit_t eject_flit,
	output logic eject_valid
);
	import noc_pkg::*;

	// buffers are numbered port*num_vcs+vc, outputs by direction code with local last
	flit_t front_a [num_ports*num_vcs];
	logic [num_ports*num_vcs-1:0] nonempty;
	logic [num_ports*num_vcs-1:0] deq;
	logic [num_ports*num_vcs-1:0] head_front;
	logic [1:0] dir [num_ports*num_vcs];
	logic [1:0] lock_dir [num_ports*num_vcs];
	logic [num_ports*num_vcs-1:0] req [num_ports+1];
	logic [num_ports*num_vcs-1:0] grant [num_ports+1];
	flit_t win_flit [num_ports+1];
	logic [2:0] win_idx [num_ports+1];
	flit_t flit_q [num_ports+1];
	logic [num_ports:0] valid_q;
	logic [num_ports:0] out_locked;
	logic [2:0] lock_owner [num_ports+1];

	for (genvar v = 0; v < num_vcs; v++)
	begin : g_gather
		assign front_a[port_anticlockwise*num_vcs+v] = anticlockwise_bufs.front[v];
		assign front_a[port_clockwise*num_vcs+v] = clockwise_bufs.front[v];
		assign front_a[port_across*num_vcs+v] = across_bufs.front[v];
	end
	assign nonempty[port_anticlockwise*num_vcs +: num_vcs] = anticlockwise_bufs.not_empty;
	assign nonempty[port_clockwise*num_vcs +: num_vcs] = clockwise_bufs.not_empty;
	assign nonempty[port_across*num_vcs +: num_vcs] = across_bufs.not_empty;
	assign anticlockwise_bufs.dequeue = deq[port_anticlockwise*num_vcs +: num_vcs];
	assign clockwise_bufs.dequeue = deq[port_clockwise*num_vcs +: num_vcs];
	assign across_bufs.dequeue = deq[port_across*num_vcs +: num_vcs];

	// opening flits are routed afresh, the rest follow the direction their head took
	always_comb
	begin
		for (int b = 0; b < num_ports*num_vcs; b++)
		begin
			head_front[b] = (front_a[b].kind == kind_head) || (front_a[b].kind == kind_header);
			dir[b] = head_front[b] ?
				route_dir(front_a[b].data[flit_data_w-1 -: node_w], node_id) : lock_dir[b];
		end
	end

	// a request needs a free or own output lock and room at the neighbour on that vc
	always_comb
	begin
		logic ok_lock;
		logic ok_flow;
		for (int o = 0; o <= num_ports; o++)
		begin
			for (int b = 0; b < num_ports*num_vcs; b++)
			begin
				ok_lock = !out_locked[o] || (lock_owner[o] == b);
				// ejection into the local processor never stalls
				if (o == port_local)
					ok_flow = 1'b1;
				else if (head_front[b])
					ok_flow = adj_vc_free[o*num_vcs+front_a[b].vc] &&
						!adj_vc_full[o*num_vcs+front_a[b].vc];
				else
					ok_flow = !adj_vc_full[o*num_vcs+front_a[b].vc];
				req[o][b] = nonempty[b] && (dir[b] == o) && ok_lock && ok_flow;
			end
		end
	end

	for (genvar o = 0; o <= num_ports; o++)
	begin : g_arb
		rr_arbiter #(
			.width(num_ports*num_vcs)
		) i_rr_arbiter (
			.clk(clk),
			.reset(reset),
			.req(req[o]),
			.advance(|grant[o]),
			.grant(grant[o])
		);
	end

	// each buffer asks one output only, so at most one grant reaches it
	always_comb
	begin
		deq = '0;
		for (int o = 0; o <= num_ports; o++)
		begin
			win_flit[o] = '0;
			win_idx[o] = '0;
			for (int b = 0; b < num_ports*num_vcs; b++)
			begin
				if (grant[o][b])
				begin
					win_flit[o] = front_a[b];
					win_idx[o] = b[2:0];
				end
			end
			deq = deq | grant[o];
		end
	end

	// registered flits towards the three links and the ejection port
	always_ff @(posedge clk)
	begin
		for (int o = 0; o <= num_ports; o++)
			flit_q[o] <= win_flit[o];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q <= '0;
			out_locked <= '0;
			for (int o = 0; o <= num_ports; o++)
				lock_owner[o] <= '0;
			for (int b = 0; b < num_ports*num_vcs; b++)
				lock_dir[b] <= port_local;
		end
		else
		begin
			for (int o = 0; o <= num_ports; o++)
			begin
				valid_q[o] <= |grant[o];
				// a head holds the output for its buffer until the tail goes through
				if (|grant[o] && win_flit[o].kind == kind_head)
				begin
					out_locked[o] <= 1'b1;
					lock_owner[o] <= win_idx[o];
				end
				else if (|grant[o] && win_flit[o].kind == kind_tail)
					out_locked[o] <= 1'b0;
			end
			// remember where the packet went so its body and tail follow
			for (int b = 0; b < num_ports*num_vcs; b++)
			begin
				if (deq[b] && front_a[b].kind == kind_head)
					lock_dir[b] <= dir[b];
			end
		end
	end

	for (genvar p = 0; p < num_ports; p++)
	begin : g_out
		assign out_flit[p] = flit_q[p];
	end
	assign out_valid = valid_q[num_ports-1:0];
	assign eject_flit = flit_q[port_local];
	assign eject_valid = valid_q[port_local];

endmodule

// ==== logic/rr_arbiter.sv ====
// round-robin arbiter over a request vector, one per switch output
`timescale 1ns/100ps

module rr_arbiter #(
	parameter int width = 6
) (
	input logic clk,
	input logic reset,
	input logic [width-1:0] req,
	input logic advance,
	output logic [width-1:0] grant
);

	logic [$clog2(width)-1:0] ptr;
	logic [$clog2(width)-1:0] winner;
	logic found;

	// scan from the pointer upwards with wrap, the first request found wins
	always_comb
	begin
		int cand;
		grant = '0;
		winner = '0;
		found = 1'b0;
		for (int i = 0; i < width; i++)
		begin
			cand = ptr + i;
			if (cand >= width)
				cand = cand - width;
			if (!found && req[cand])
			begin
				found = 1'b1;
				grant[cand] = 1'b1;
				winner = cand[$clog2(width)-1:0];
			end
		end
	end

	// the winner becomes lowest priority once its grant is used
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (advance && found)
			ptr <= (winner == width - 1) ? '0 : winner + 1'b1;
	end

endmodule

// ==== logic/input_port.sv ====
// one network input port of the node, buffering flits per virtual channel and tracking reservation
`timescale 1ns/100ps

module input_port (
	input logic clk,
	input logic reset,
	input noc_pkg::flit_t flit,
	input logic valid,
	output logic [noc_pkg::num_vcs-1:0] vc_free,
	output logic [noc_pkg::num_vcs-1:0] vc_full,
	vc_port_if.buffer bufs
);
	import noc_pkg::*;

	logic [num_vcs-1:0] wr_en;
	logic [num_vcs-1:0] full;
	logic [num_vcs-1:0] empty;
	logic [num_vcs-1:0] reserved;
	logic [num_vcs-1:0] set_res;
	logic [num_vcs-1:0] clr_res;
	logic opens_packet;

	// a head or a header opens a packet on its channel
	assign opens_packet = (flit.kind == kind_head) || (flit.kind == kind_header);

	for (genvar v = 0; v < num_vcs; v++)
	begin : g_vc
		// the vc field picks the buffer; a flit sent to a full buffer is dropped here
		assign wr_en[v] = valid && (flit.vc == v) && !full[v];

		vc_fifo #(
			.depth(vc_depth)
		) i_vc_fifo (
			.clk(clk),
			.reset(reset),
			.wr_en(wr_en[v]),
			.wr_flit(flit),
			.rd_en(bufs.dequeue[v]),
			.front(bufs.front[v]),
			.full(full[v]),
			.empty(empty[v])
		);

		// the channel is reserved as soon as the opening flit is stored
		assign set_res[v] = wr_en[v] && opens_packet;

		// and released when the closing flit leaves, a header being both ends at once
		assign clr_res[v] = bufs.dequeue[v] && !empty[v] &&
			((bufs.front[v].kind == kind_tail) || (bufs.front[v].kind == kind_header));
	end

	assign bufs.not_empty = ~empty;

	// on/off flags towards the upstream neighbour
	assign vc_free = ~reserved;
	assign vc_full = full;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			reserved <= '0;
		end
		else
		begin
			for (int v = 0; v < num_vcs; v++)
			begin
				// a new packet written in the same cycle as the old one leaves keeps the channel
				if (set_res[v])
					reserved[v] <= 1'b1;
				else if (clr_res[v])
					reserved[v] <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/vc_fifo.sv ====
// strict-order flit buffer for one virtual channel that each input port instantiates twice
`timescale 1ns/100ps

module vc_fifo #(
	parameter int depth = noc_pkg::vc_depth
) (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input noc_pkg::flit_t wr_flit,
	input logic rd_en,
	output noc_pkg::flit_t front,
	output logic full,
	output logic empty
);
	import noc_pkg::*;

	// flit slots addressed by the two pointers
	flit_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_wr;
	logic do_rd;

	// a write into a full buffer or a read from an empty one is ignored
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign full = (count == depth);
	assign empty = (count == 0);

	// the oldest flit is visible without a read strobe
	assign front = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// pointers wrap at depth, which need not be a power of two
			if (do_wr)
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/vc_port_if.sv ====
// links one input port's two buffers to the output switch, one instance per input port
`timescale 1ns/100ps

interface vc_port_if;
	import noc_pkg::*;

	// oldest flit of each channel buffer
	flit_t front [num_vcs];

	// set while the matching buffer holds at least one flit
	logic [num_vcs-1:0] not_empty;

	// pops the front of the matching buffer on the next edge
	logic [num_vcs-1:0] dequeue;

	// the input port owns the buffers
	modport buffer (
		output front,
		output not_empty,
		input dequeue
	);

	// the switch reads fronts and decides what leaves
	modport switch (
		input front,
		input not_empty,
		output dequeue
	);

endinterface

// ==== logic/noc_pkg.sv ====
// network sizes, flit format, direction codes and the routing rule, imported by every node block
package noc_pkg;

	// ring of eight nodes, each with three network ports
	localparam int num_nodes = 8;
	localparam int node_w = $clog2(num_nodes);
	localparam int num_ports = 3;

	// two virtual channels per input port, each buffer two flits deep
	localparam int num_vcs = 2;
	localparam int vc_w = $clog2(num_vcs);
	localparam int vc_depth = 2;
	localparam int flit_data_w = 15;

	// direction codes double as output indices, with the ejection port last
	localparam logic [1:0] port_anticlockwise = 2'd0;
	localparam logic [1:0] port_clockwise = 2'd1;
	localparam logic [1:0] port_across = 2'd2;
	localparam logic [1:0] port_local = 2'd3;

	// kind_header is a whole packet in one flit
	typedef enum logic [1:0] {
		kind_tail = 2'b00,
		kind_head = 2'b01,
		kind_body = 2'b10,
		kind_header = 2'b11
	} flit_kind_t;

	// head and header flits carry destination in the top data bits, then source, then payload
	typedef struct packed {
		flit_kind_t kind;
		logic [vc_w-1:0] vc;
		logic [flit_data_w-1:0] data;
	} flit_t;

	// shortest path on the spidergon ring, from the distance measured clockwise
	function automatic logic [1:0] route_dir(input logic [node_w-1:0] dest,
		input logic [node_w-1:0] cur);
		logic [node_w-1:0] d;
		d = dest - cur;
		case (d)
			3'd0: route_dir = port_local;
			3'd1, 3'd2: route_dir = port_clockwise;
			3'd6, 3'd7: route_dir = port_anticlockwise;
			default: route_dir = port_across;
		endcase
	endfunction

endpackage
